//--- common/pd_defines.svh
/*
	P-D instruction decoder widths and build options
	Word and R0 flag widths, IN/OU user-mode legality default
*/

`ifndef PD_DEFINES_SVH
`define PD_DEFINES_SVH

// Instruction and bus word width
`define PD_WORD_BITS 16

// R0 condition flags Z M V C L E G Y X
`define PD_R0_BITS 9

// 1 makes IN and OU illegal in user mode
`define PD_INOU_USER_ILLEGAL 1'b1

`endif

//--- common/pd_pkg.sv
/*
	P-D instruction decoder types
	Word and flag vectors, execution phases, decoded group flags and ALU selects
*/

`include "pd_defines.svh"

package pd_pkg;

	typedef logic [0:`PD_WORD_BITS-1] word_t;	// Bit 0 is the MSB
	typedef logic [0:`PD_R0_BITS-1] r0_flags_t;	// Z M V C L E G Y X
	typedef logic [0:2] field_t;	// A, B or C register field

	// Instruction execution phases
	typedef enum logic [2:0] {
		IDLE,	// Waiting for an instruction
		PP,	// Preparation
		WA,	// Argument fetch
		WE,	// Execute
		WW,	// Write back
		KC	// Cycle end
	} pd_phase_t;

	// Decoded opcode groups, all active high
	typedef struct packed {
		logic two_arg;	// 020..057
		logic ka1;	// 060..067
		logic js;	// 070
		logic ka2;	// 071
		logic c_grp;	// 072
		logic s_grp;	// 073
		logic j_grp;	// 074
		logic store;	// RW or PW
		logic inou;	// IN or OU
		logic hlt;
		logic c_zero;	// Argument in next word
		logic b_zero;	// No B modification
	} pd_decode_t;

	// ALU function selects
	typedef struct packed {
		logic arith;	// 1 arithmetic, 0 logic
		logic plus;
		logic minus;
		logic inc;	// A + 1
		logic dec;	// A - 1
		logic [1:0] logic_op;	// OR, AND-NOT, XOR, pass
	} alu_fn_t;

endpackage

//--- logic/decoder16.sv
/*
	4-to-16 decoder with two active-low enables
	Selected output goes low, the others stay high
*/

`timescale 1ns/1ps

module decoder16 (
	input logic en1_,
	input logic en2_,
	input logic [3:0] sel,
	output logic [0:15] o_	// Output n for sel == n
);

	always_comb begin
		o_ = '1;	// All outputs inactive
		if (!en1_ && !en2_) begin
			o_[sel] = 1'b0;
		end
	end

endmodule

//--- logic/decoder_bcd.sv
/*
	BCD 4-to-10 decoder with active-low outputs
	With d tied as an enable only outputs 0..7 matter
*/

`timescale 1ns/1ps

module decoder_bcd (
	input logic a,	// Weight 1
	input logic b,	// Weight 2
	input logic c,	// Weight 4
	input logic d,	// Weight 8
	output logic [0:9] o_
);

	logic [3:0] num;

	assign num = {d, c, b, a};

	always_comb begin
		o_ = '1;
		if (num < 4'd10) begin	// Codes 10..15 select nothing
			o_[num] = 1'b0;
		end
	end

endmodule

//--- pd/pd.sv
/*
	P-D instruction decoder
	Instruction register, opcode group decode, illegal and ineffective detection,
	ALU selects and next-phase requests for the phase sequencer
*/

`timescale 1ns/1ps
`include "pd_defines.svh"

module pd #(
	parameter bit INOU_USER_ILLEGAL = `PD_INOU_USER_ILLEGAL
) (
	input logic clk_sys,
	input logic rst_n,
	input pd_pkg::word_t w,	// W bus
	input logic w_ir,	// W -> IR strobe
	input logic q,	// System flag, 1 in user mode
	input logic mc_3,	// Three pre-modifications in a row
	input pd_pkg::r0_flags_t r0,
	input logic p_,	// Branch-skip flag, active low
	input pd_pkg::pd_phase_t phase,
	output pd_pkg::word_t ir,
	output pd_pkg::pd_decode_t dec,
	output pd_pkg::alu_fn_t alu,
	output logic xi,	// Illegal instruction
	output logic nef,	// Ineffective instruction
	output logic start,
	output pd_pkg::pd_phase_t enter
);

	logic [0:15] g01_;	// 020..037
	logic [0:15] g10_;	// 040..057
	logic [0:15] g11_;	// 060..077
	logic [0:9] a_eq_;	// A field value
	logic [0:9] s_dec_;	// S group by A field
	logic [0:9] bn_dec_;	// B/N group by A field
	pd_pkg::field_t b_fld;
	pd_pkg::field_t c_fld;
	logic ir01, b_1, c_hi, snef, md;
	logic rw_, pw_, ou_, in_;
	logic aw_, ac_, sw_, cw_, or_, nr_, er_;
	logic awt_, irb_, drb_, cwt_, js_, ka2_, c_, s_, j_, bn_;
	logic inou, store, ill_user_, ill_op_, j_fail, js_fail;
	logic pp, wa, we, ww, ewa, ewe, eww, ekc_;

	// Instruction register loads only between instructions
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ir <= '0;
		end else if (start) begin
			ir <= w;
		end
	end

	assign start = w_ir & (phase == pd_pkg::IDLE);

	// Opcode space split on IR bits 0..1
	decoder16 u_dec01 (.en1_(ir[0]), .en2_(~ir[1]), .sel(ir[2:5]), .o_(g01_));
	decoder16 u_dec10 (.en1_(~ir[0]), .en2_(ir[1]), .sel(ir[2:5]), .o_(g10_));
	decoder16 u_dec11 (.en1_(~ir[0]), .en2_(~ir[1]), .sel(ir[2:5]), .o_(g11_));

	assign rw_ = g01_[4];
	assign pw_ = g01_[5];
	assign ou_ = g01_[13];
	assign in_ = g01_[14];

	assign aw_ = g10_[0];
	assign ac_ = g10_[1];
	assign sw_ = g10_[2];
	assign cw_ = g10_[3];
	assign or_ = g10_[4];
	assign nr_ = g10_[6];
	assign er_ = g10_[8];

	assign awt_ = g11_[0];
	assign irb_ = g11_[2];
	assign drb_ = g11_[3];
	assign cwt_ = g11_[4];
	assign js_ = g11_[8];
	assign ka2_ = g11_[9];
	assign c_ = g11_[10];
	assign s_ = g11_[11];
	assign j_ = g11_[12];
	assign bn_ = g11_[15];	// B/N group at opcode 077

	// S and B/N field decoders use their group as enable
	decoder_bcd u_dec_a (.a(ir[9]), .b(ir[8]), .c(ir[7]), .d(1'b0), .o_(a_eq_));
	decoder_bcd u_dec_s (.a(ir[9]), .b(ir[8]), .c(ir[7]), .d(s_), .o_(s_dec_));
	decoder_bcd u_dec_bn (.a(ir[9]), .b(ir[8]), .c(ir[7]), .d(bn_), .o_(bn_dec_));

	assign b_fld = ir[10:12];
	assign c_fld = ir[13:15];
	assign ir01 = ir[0] | ir[1];	// Low for opcodes below 020
	assign b_1 = (b_fld == 3'd1);
	assign c_hi = |c_fld[0:1];	// IR bits 13..14
	assign snef = ~(a_eq_[5] & a_eq_[6] & a_eq_[7]);	// A field 5..7
	assign md = ~bn_dec_[5];
	assign inou = ~(in_ & ou_);
	assign store = ~(rw_ & pw_);

	always_comb begin
		dec.two_arg = ~(&g01_ & &g10_);
		dec.ka1 = ~&g11_[0:7];
		dec.js = ~js_;
		dec.ka2 = ~ka2_;
		dec.c_grp = ~c_;
		dec.s_grp = ~s_;
		dec.j_grp = ~j_;
		dec.store = store;
		dec.inou = inou;
		dec.hlt = ~s_dec_[0];
		dec.c_zero = (c_fld == '0);
		dec.b_zero = (b_fld == '0);
	end

	// Illegal in user mode
	assign ill_user_ = ~((INOU_USER_ILLEGAL & inou & q) | (q & ~s_) | (q & snef & ~bn_));
	// Illegal in any mode
	assign ill_op_ = ~((md & mc_3) | (~c_ & b_1 & c_hi) | (snef & ~s_));
	assign xi = ~(ill_user_ & ill_op_ & ir01);

	// J group with its condition flag clear
	assign j_fail = ~j_ & (
		(~a_eq_[1] & ~r0[4]) |	// JL
		(~a_eq_[2] & ~r0[5]) |	// JE
		(~a_eq_[3] & ~r0[6]) |	// JG
		(~a_eq_[4] & ~r0[0]) |	// JZ
		(~a_eq_[5] & ~r0[1]) |	// JM
		(~a_eq_[6] & r0[5]));	// JN skips on E

	assign js_fail = ~js_ & (
		(~a_eq_[4] & ~r0[2]) |	// JVS
		(~a_eq_[5] & ~r0[8]) |	// JXS
		(~a_eq_[6] & ~r0[7]) |	// JYS
		(~a_eq_[7] & ~r0[3]));	// JCS

	assign nef = xi | ~p_ | j_fail | js_fail;

	always_comb begin
		alu.plus = ~(aw_ & ac_ & awt_ & irb_);
		alu.minus = ~(sw_ & cw_ & cwt_ & drb_);
		alu.inc = ~irb_;
		alu.dec = ~drb_;
		alu.arith = alu.plus | alu.minus;
		alu.logic_op = {or_ & nr_, or_ & er_};	// Pass unless OR, NR or ER
	end

	// Next-phase requests
	assign pp = (phase == pd_pkg::PP);
	assign wa = (phase == pd_pkg::WA);
	assign we = (phase == pd_pkg::WE);
	assign ww = (phase == pd_pkg::WW);

	assign ewa = pp & ~nef & dec.two_arg & dec.c_zero;	// Argument in next word
	assign ewe = (pp & ~nef & ~(dec.two_arg & dec.c_zero)) | wa;
	assign eww = we & store;
	assign ekc_ = ~((pp & nef) | (we & ~store) | ww);

	always_comb begin
		if (ewa) begin
			enter = pd_pkg::WA;
		end else if (ewe) begin
			enter = pd_pkg::WE;
		end else if (eww) begin
			enter = pd_pkg::WW;
		end else if (!ekc_) begin
			enter = pd_pkg::KC;
		end else begin
			enter = pd_pkg::IDLE;	// From KC or IDLE
		end
	end

	// Illegal instructions always end straight after PP
	a_xi_skips: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(pp && xi) |-> (nef && enter == pd_pkg::KC));

endmodule

//--- pd/phase_seq.sv
/*
	Instruction execution phase sequencer
	Leaves IDLE on start, then follows the decoder's enter requests
*/

`timescale 1ns/1ps

module phase_seq (
	input logic clk_sys,
	input logic rst_n,
	input logic start,	// Instruction loaded into IR
	input pd_pkg::pd_phase_t enter,	// Requested next phase
	output pd_pkg::pd_phase_t phase,
	output logic cycle_end	// High while in KC
);

	pd_pkg::pd_phase_t phase_nxt;

	always_comb begin
		if (phase == pd_pkg::IDLE) begin
			phase_nxt = start ? pd_pkg::PP : pd_pkg::IDLE;
		end else begin
			phase_nxt = enter;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			phase <= pd_pkg::IDLE;
			cycle_end <= 1'b0;
		end else begin
			phase <= phase_nxt;
			cycle_end <= (phase_nxt == pd_pkg::KC);	// Aligned with KC
		end
	end

	// Cycle end returns to idle
	a_kc_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		phase == pd_pkg::KC |=> phase == pd_pkg::IDLE);

	// Every active phase lasts one clock
	a_one_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		phase != pd_pkg::IDLE |=> phase != $past(phase));

endmodule

//--- logic/pd_unit.sv
/*
	P-D instruction decode unit
	Decoder with instruction register, plus the phase sequencer
*/

`timescale 1ns/1ps

module pd_unit (
	input logic clk_sys,
	input logic rst_n,
	input pd_pkg::word_t w,
	input logic w_ir,
	input logic q,
	input logic mc_3,
	input pd_pkg::r0_flags_t r0,
	input logic p_,
	output pd_pkg::word_t ir,
	output pd_pkg::pd_decode_t dec,
	output pd_pkg::alu_fn_t alu,
	output logic xi,
	output logic nef,
	output pd_pkg::pd_phase_t phase,
	output logic cycle_end
);

	logic start;	// IR load in IDLE
	pd_pkg::pd_phase_t enter;	// Decoder's next-phase request

	pd u_pd (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.w(w),
		.w_ir(w_ir),
		.q(q),
		.mc_3(mc_3),
		.r0(r0),
		.p_(p_),
		.phase(phase),
		.ir(ir),
		.dec(dec),
		.alu(alu),
		.xi(xi),
		.nef(nef),
		.start(start),
		.enter(enter)
	);

	phase_seq u_phase (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.start(start),
		.enter(enter),
		.phase(phase),
		.cycle_end(cycle_end)
	);

endmodule

//--- dv/tb_pd_unit.sv
/*
	Testbench for the P-D instruction decode unit
	Directed and random instructions, checked against a reference model by assertions
*/

`timescale 1ns/1ps
`include "pd_defines.svh"

module tb_pd_unit;

	localparam int TIMEOUT_CYCLES = 1500;	// 200 instructions of up to 6 cycles
	localparam int N_RANDOM = 160;
	localparam int F_Z = 0, F_M = 1, F_V = 2, F_C = 3, F_L = 4, F_E = 5, F_G = 6, F_Y = 7, F_X = 8;
	localparam logic [5:0] ALU_OPS [0:10] = '{6'o40, 6'o41, 6'o42, 6'o43, 6'o44, 6'o46,
		6'o50, 6'o60, 6'o62, 6'o63, 6'o64};

	logic clk_sys = 1'b0;
	logic rst_n, w_ir, q, mc_3, p_;
	pd_pkg::word_t w, ir, exp_ir;
	pd_pkg::r0_flags_t r0;
	pd_pkg::pd_decode_t dec, exp_dec;
	pd_pkg::alu_fn_t alu, exp_alu;
	pd_pkg::pd_phase_t phase, exp_phase;
	logic xi, nef, cycle_end, exp_xi, exp_nef, j_fail, js_fail;
	logic [5:0] m_op;
	logic [2:0] m_a, m_b, m_c;
	logic [31:0] rnd;
	int cycles = 0;

	pd_unit u_dut (.clk_sys(clk_sys), .rst_n(rst_n), .w(w), .w_ir(w_ir), .q(q), .mc_3(mc_3),
		.r0(r0), .p_(p_), .ir(ir), .dec(dec), .alu(alu), .xi(xi), .nef(nef), .phase(phase),
		.cycle_end(cycle_end));

	always #10 clk_sys = ~clk_sys;

	// Reference model of the IR fields
	assign m_op = exp_ir[0:5];
	assign m_a = exp_ir[7:9];
	assign m_b = exp_ir[10:12];
	assign m_c = exp_ir[13:15];	// m_c[2:1] are IR bits 13..14

	always_comb begin
		exp_dec.two_arg = (m_op >= 6'o20) && (m_op <= 6'o57);
		exp_dec.ka1 = (m_op >= 6'o60) && (m_op <= 6'o67);
		exp_dec.js = (m_op == 6'o70);
		exp_dec.ka2 = (m_op == 6'o71);
		exp_dec.c_grp = (m_op == 6'o72);
		exp_dec.s_grp = (m_op == 6'o73);
		exp_dec.j_grp = (m_op == 6'o74);
		exp_dec.store = (m_op == 6'o24) || (m_op == 6'o25);	// RW, PW
		exp_dec.inou = (m_op == 6'o35) || (m_op == 6'o36);	// OU, IN
		exp_dec.hlt = exp_dec.s_grp && (m_a == 3'd0);
		exp_dec.c_zero = (m_c == 3'd0);
		exp_dec.b_zero = (m_b == 3'd0);
		exp_xi = (m_op < 6'o20) || (exp_dec.s_grp && m_a >= 3'd5)
			|| (q && `PD_INOU_USER_ILLEGAL && exp_dec.inou) || (q && exp_dec.s_grp)
			|| (q && m_op == 6'o77 && m_a >= 3'd5)	// User BN
			|| (exp_dec.c_grp && m_b == 3'd1 && m_c[2:1] != 2'd0)
			|| (m_op == 6'o77 && m_a == 3'd5 && mc_3);	// MD
		case (m_a)
			3'd1: j_fail = !r0[F_L];
			3'd2: j_fail = !r0[F_E];
			3'd3: j_fail = !r0[F_G];
			3'd4: j_fail = !r0[F_Z];
			3'd5: j_fail = !r0[F_M];
			3'd6: j_fail = r0[F_E];	// JN
			default: j_fail = 1'b0;
		endcase
		case (m_a)
			3'd4: js_fail = !r0[F_V];
			3'd5: js_fail = !r0[F_X];
			3'd6: js_fail = !r0[F_Y];
			3'd7: js_fail = !r0[F_C];
			default: js_fail = 1'b0;
		endcase
		exp_nef = exp_xi || !p_ || (exp_dec.j_grp && j_fail) || (exp_dec.js && js_fail);
		exp_alu = '0;
		exp_alu.logic_op = 2'd3;	// Pass
		case (m_op)
			6'o40, 6'o41, 6'o60: {exp_alu.arith, exp_alu.plus} = 2'b11;
			6'o62: {exp_alu.arith, exp_alu.plus, exp_alu.inc} = 3'b111;	// IRB
			6'o42, 6'o43, 6'o64: {exp_alu.arith, exp_alu.minus} = 2'b11;
			6'o63: {exp_alu.arith, exp_alu.minus, exp_alu.dec} = 3'b111;	// DRB
			6'o44: exp_alu.logic_op = 2'd0;
			6'o46: exp_alu.logic_op = 2'd1;
			6'o50: exp_alu.logic_op = 2'd2;
			default: ;
		endcase
	end

	// Model IR and phase
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			exp_ir <= '0;
			exp_phase <= pd_pkg::IDLE;
		end else begin
			case (exp_phase)
				pd_pkg::IDLE: if (w_ir) begin
					exp_ir <= w;
					exp_phase <= pd_pkg::PP;
				end
				pd_pkg::PP: exp_phase <= exp_nef ? pd_pkg::KC :
					(exp_dec.two_arg && exp_dec.c_zero) ? pd_pkg::WA : pd_pkg::WE;
				pd_pkg::WA: exp_phase <= pd_pkg::WE;
				pd_pkg::WE: exp_phase <= exp_dec.store ? pd_pkg::WW : pd_pkg::KC;
				pd_pkg::WW: exp_phase <= pd_pkg::KC;
				default: exp_phase <= pd_pkg::IDLE;
			endcase
		end
	end

	task automatic halt_on_mismatch(input string what);
		$display("error %0t: %s does not match the model", $time, what);
		$display("TESTS FAILED");
		$fatal(1, "check failed");
	endtask

	a_reset: assert property (@(posedge clk_sys)
		!rst_n |=> (ir == '0 && phase == pd_pkg::IDLE && !cycle_end))
		else halt_on_mismatch("reset state");
	a_ir: assert property (@(posedge clk_sys) disable iff (!rst_n) ir == exp_ir)
		else halt_on_mismatch("ir");
	a_dec: assert property (@(posedge clk_sys) disable iff (!rst_n) dec == exp_dec)
		else halt_on_mismatch("dec");
	a_xi: assert property (@(posedge clk_sys) disable iff (!rst_n) xi == exp_xi)
		else halt_on_mismatch("xi");
	a_nef: assert property (@(posedge clk_sys) disable iff (!rst_n) nef == exp_nef)
		else halt_on_mismatch("nef");
	a_alu: assert property (@(posedge clk_sys) disable iff (!rst_n) alu == exp_alu)
		else halt_on_mismatch("alu");
	a_phase: assert property (@(posedge clk_sys) disable iff (!rst_n)
		phase == exp_phase) else halt_on_mismatch("phase");
	a_cycle_end: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cycle_end == (exp_phase == pd_pkg::KC)) else halt_on_mismatch("cycle_end");
	a_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cycle_end |=> !cycle_end) else halt_on_mismatch("cycle_end pulse width");

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout: the instruction stream did not finish within %0d cycles", cycles);
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic pd_pkg::word_t make_word(input logic [5:0] op, input logic [2:0] a,
		input logic [2:0] b, input logic [2:0] c);
		return {op, 1'b0, a, b, c};	// D bit clear
	endfunction

	// Load one word, then wait for cycle end while w_ir and W carry noise
	task automatic run_instr(input pd_pkg::word_t word, input logic q_in, input logic mc3_in,
		input logic p_in);
		logic done;
		done = 1'b0;
		@(posedge clk_sys);
		rnd = $urandom;
		w <= word;
		w_ir <= 1'b1;
		q <= q_in;
		mc_3 <= mc3_in;
		p_ <= p_in;
		r0 <= rnd[8:0];
		while (!done) begin
			@(negedge clk_sys);
			done = cycle_end;
			if (!done) begin
				@(posedge clk_sys);
				rnd = $urandom;
				w_ir <= rnd[0];	// Ignored outside IDLE
				w <= rnd[31:16];
				r0 <= rnd[9:1];
			end
		end
	endtask

	initial begin
		rnd = $urandom(32'h3f7f);
		rst_n = 1'b0;
		w = '0;
		w_ir = 1'b0;
		q = 1'b0;
		mc_3 = 1'b0;
		r0 = '0;
		p_ = 1'b1;
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		run_instr(make_word(6'o36, 3'd0, 3'd1, 3'd2), 1'b1, 1'b0, 1'b1);	// IN in user mode
		run_instr(make_word(6'o35, 3'd0, 3'd1, 3'd2), 1'b1, 1'b0, 1'b1);	// OU in user mode
		run_instr(make_word(6'o36, 3'd0, 3'd1, 3'd2), 1'b0, 1'b0, 1'b1);
		for (int i = 5; i < 8; i++) begin
			run_instr(make_word(6'o73, 3'(i), 3'd0, 3'd1), 1'b0, 1'b0, 1'b1);
		end
		run_instr(make_word(6'o73, 3'd0, 3'd0, 3'd0), 1'b1, 1'b0, 1'b1);	// HLT in user mode
		run_instr(make_word(6'o73, 3'd0, 3'd0, 3'd0), 1'b0, 1'b0, 1'b1);
		run_instr(make_word(6'o77, 3'd5, 3'd0, 3'd0), 1'b0, 1'b1, 1'b1);	// MD with mc_3
		run_instr(make_word(6'o77, 3'd5, 3'd0, 3'd0), 1'b1, 1'b0, 1'b1);
		run_instr(make_word(6'o77, 3'd4, 3'd0, 3'd0), 1'b1, 1'b0, 1'b1);
		run_instr(make_word(6'o72, 3'd0, 3'd1, 3'd2), 1'b0, 1'b0, 1'b1);
		run_instr(make_word(6'o72, 3'd0, 3'd1, 3'd1), 1'b0, 1'b0, 1'b1);
		for (int i = 0; i < 8; i++) begin
			run_instr(make_word(6'o74, 3'(i), 3'd0, 3'd3), 1'b0, 1'b0, 1'b1);
		end
		for (int i = 4; i < 8; i++) begin
			run_instr(make_word(6'o70, 3'(i), 3'd0, 3'd3), 1'b0, 1'b0, 1'b1);
		end
		run_instr(make_word(6'o40, 3'd1, 3'd0, 3'd2), 1'b0, 1'b0, 1'b0);	// Skipped by p_
		foreach (ALU_OPS[i]) begin
			run_instr(make_word(ALU_OPS[i], 3'd2, 3'd0, 3'd0), 1'b0, 1'b0, 1'b1);
		end
		run_instr(make_word(6'o24, 3'd1, 3'd0, 3'd0), 1'b0, 1'b0, 1'b1);	// Longest path
		run_instr(make_word(6'o25, 3'd1, 3'd2, 3'd3), 1'b0, 1'b0, 1'b1);
		run_instr(make_word(6'o00, 3'd0, 3'd0, 3'd0), 1'b0, 1'b0, 1'b1);
		repeat (N_RANDOM) begin
			rnd = $urandom;
			run_instr(rnd[15:0], rnd[16], rnd[17], rnd[20:18] != 3'd0);
		end
		@(posedge clk_sys);
		w_ir <= 1'b0;
		@(negedge clk_sys);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- sources.f
+incdir+common
common/pd_pkg.sv
logic/decoder16.sv
logic/decoder_bcd.sv
pd/pd.sv
pd/phase_seq.sv
logic/pd_unit.sv
dv/tb_pd_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the P-D decode unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module tb_pd_unit --Mdir obj_dir -o sim_pd_unit

./obj_dir/sim_pd_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
	exit 0
fi
exit 1
